/* common/ic_pkg.sv */
// ******************************
// icache miss controller package
// widths, one-hot miss states, ack and
// diagnostic bit positions, bus types
// ******************************
`default_nettype none

package ic_pkg;

	// widths
	localparam int STATE_W     = 6;
	localparam int ACK_W       = 2;
	localparam int TYPE_W      = 4;
	localparam int DIAG_W      = 4;
	localparam int RAM_WE_W    = 2;
	localparam int FILL_ADDR_W = 2;

	// acknowledge bits, error wins over normal
	localparam int ACK_NORMAL_BIT = 0;
	localparam int ACK_ERROR_BIT  = 1;

	// diagnostic strobe positions
	localparam int DIAG_LD_TAG   = 0;
	localparam int DIAG_ST_TAG   = 1;
	localparam int DIAG_LD_CACHE = 2;
	localparam int DIAG_ST_CACHE = 3;

	// one-hot state bit indices
	localparam int S_IDLE_BIT     = 0;
	localparam int S_NC_REQ_BIT   = 1;
	localparam int S_REQ_BIT      = 2;
	localparam int S_FILL_2ND_BIT = 3;
	localparam int S_REQ2_BIT     = 4;
	localparam int S_FILL_4TH_BIT = 5;

	localparam logic [STATE_W-1:0] S_IDLE     = STATE_W'(1) << S_IDLE_BIT;
	localparam logic [STATE_W-1:0] S_NC_REQ   = STATE_W'(1) << S_NC_REQ_BIT;
	localparam logic [STATE_W-1:0] S_REQ      = STATE_W'(1) << S_REQ_BIT;
	localparam logic [STATE_W-1:0] S_FILL_2ND = STATE_W'(1) << S_FILL_2ND_BIT;
	localparam logic [STATE_W-1:0] S_REQ2     = STATE_W'(1) << S_REQ2_BIT;
	localparam logic [STATE_W-1:0] S_FILL_4TH = STATE_W'(1) << S_FILL_4TH_BIT;

	// bus transaction types, always a load
	localparam logic [TYPE_W-1:0] TYPE_CACHE_LD = 4'b0000;
	localparam logic [TYPE_W-1:0] TYPE_NC_LD    = 4'b0010;

endpackage

`default_nettype wire

/* common/ic_miss_if.sv */
// ******************************
// miss state bus
// state, decoded acks, end pulses and
// the miss request between blocks
// ******************************
`timescale 1ns/100ps
`default_nettype none

interface ic_miss_if;

	// one-hot miss state
	logic [ic_pkg::STATE_W-1:0] state;

	// decoded memory acknowledges
	logic normal_ack;
	logic error_ack;

	// ack seen in the last fill state or the nc state
	logic fill_end;
	logic nc_end;

	// miss detected while idle
	logic icu_miss;

	modport fsm (output state, normal_ack, error_ack, fill_end, nc_end,
		input icu_miss);

	modport stall (input state, fill_end, nc_end, output icu_miss);

	modport wr (input state, normal_ack, error_ack);

	modport diag (input state);

endinterface

`default_nettype wire

/* common/ic_diag_if.sv */
// ******************************
// diagnostic bus
// qualified diag strobes, flush,
// diag window and cache enable
// ******************************
`timescale 1ns/100ps
`default_nettype none

interface ic_diag_if;

	// strobes qualified by idle
	logic diag_st_cache;
	logic diag_st_tag;

	// flush qualified by idle and cache enable
	logic flush;

	// diag or flush in E, then in C
	logic valid_diag_e;
	logic valid_diag_c;

	// either stage busy with a diagnostic
	logic valid_diag_window;

	// cache enable as latched while idle
	logic cache_en;

	modport src (output diag_st_cache, diag_st_tag, flush, valid_diag_e,
		valid_diag_c, valid_diag_window, cache_en);

	modport sink (input diag_st_cache, diag_st_tag, flush, valid_diag_e,
		valid_diag_c, valid_diag_window, cache_en);

endinterface

`default_nettype wire

/* hw/ic_diag_decode.sv */
// ******************************
// diagnostic decode
// qualifies diag and flush by idle, moves
// them into C, latches cache enable
// ******************************
`timescale 1ns/100ps
`default_nettype none

module ic_diag_decode (
	input  wire                      clk,
	input  wire                      reset_l,
	input  wire                      iu_psr_ice,
	input  wire                      iu_flush_e,
	input  wire [ic_pkg::DIAG_W-1:0] iu_ic_diag_e,
	ic_miss_if.diag                  miss,
	ic_diag_if.src                   diag,
	output logic                     diag_ld_cache_c,
	output logic                     icu_hold_req
);

	logic idle;
	logic flush_req;
	logic diag_ld_cache_e;

	assign idle = miss.state[ic_pkg::S_IDLE_BIT];

	// flush is a nop with the cache off
	assign flush_req = iu_flush_e & iu_psr_ice;

	// diag access only runs with nothing outstanding
	assign diag.flush         = flush_req & idle;
	assign diag.diag_st_cache = iu_ic_diag_e[ic_pkg::DIAG_ST_CACHE] & idle;
	assign diag.diag_st_tag   = iu_ic_diag_e[ic_pkg::DIAG_ST_TAG] & idle;
	assign diag_ld_cache_e    = iu_ic_diag_e[ic_pkg::DIAG_LD_CACHE] & idle;

	assign diag.valid_diag_e = diag.flush | iu_ic_diag_e[ic_pkg::DIAG_LD_TAG] |
		iu_ic_diag_e[ic_pkg::DIAG_ST_TAG] | iu_ic_diag_e[ic_pkg::DIAG_LD_CACHE] |
		iu_ic_diag_e[ic_pkg::DIAG_ST_CACHE];

	assign diag.valid_diag_window = diag.valid_diag_e | diag.valid_diag_c;

	// busy FSM turns any diag or flush into a hold
	assign icu_hold_req = (|iu_ic_diag_e) | flush_req;

	// E to C stage, cache enable only sampled in idle
	always_ff @(posedge clk) begin
		if (!reset_l) begin
			diag.valid_diag_c <= 1'b0;
			diag_ld_cache_c   <= 1'b0;
			diag.cache_en     <= 1'b0;
		end else begin
			diag.valid_diag_c <= diag.valid_diag_e;
			diag_ld_cache_c   <= diag_ld_cache_e;
			if (idle) begin
				diag.cache_en <= iu_psr_ice;
			end
		end
	end

	// a qualified write or flush keeps the FSM idle into the next cycle
	a_diag_in_idle: assert property (@(posedge clk) disable iff (!reset_l)
		(diag.flush | diag.diag_st_cache | diag.diag_st_tag)
		|-> idle ##1 miss.state[ic_pkg::S_IDLE_BIT]);

endmodule

`default_nettype wire

/* hw/ic_stall_gen.sv */
// ******************************
// stall generation
// miss detect, branch pending during a
// fill, ibuffer stall and iu hold
// ******************************
`timescale 1ns/100ps
`default_nettype none

module ic_stall_gen (
	input  wire      clk,
	input  wire      reset_l,
	input  wire      icu_hit,
	input  wire      iu_brtaken_e,
	input  wire      ibuf_full,
	input  wire      ic_drty,
	input  wire      icu_hold_req,
	ic_miss_if.stall miss,
	ic_diag_if.sink  diag,
	output logic     icu_stall,
	output logic     icu_hold
);

	logic idle;
	logic set_stall;
	logic stall_valid;
	logic fourth_fill_d1;
	logic nc_fill_d1;
	logic reset_d1_l;

	assign idle = miss.state[ic_pkg::S_IDLE_BIT];

	// miss only from idle with no diag in C, and not in the
	// cycle after an end or an error, where the fetch is replayed
	assign miss.icu_miss = (!diag.cache_en | !icu_hit) & idle & !diag.valid_diag_c &
		!fourth_fill_d1 & !nc_fill_d1 & !ic_drty;

	// branch taken while busy waits for the FSM to return
	assign set_stall = (iu_brtaken_e | stall_valid) & !idle;

	always_ff @(posedge clk) begin
		if (!reset_l) begin
			stall_valid    <= 1'b0;
			fourth_fill_d1 <= 1'b0;
			nc_fill_d1     <= 1'b0;
		end else begin
			stall_valid    <= set_stall;
			// a pending branch refetches anyway
			fourth_fill_d1 <= miss.fill_end & !stall_valid;
			nc_fill_d1     <= miss.nc_end & !stall_valid;
		end
	end

	// low for the first cycle out of reset
	always_ff @(posedge clk) begin
		reset_d1_l <= reset_l;
	end

	// ******************************
	// ibuffer stall and iu hold
	// ******************************

	// hit is stale while the last fill word lands in the ram
	assign icu_stall = miss.icu_miss | !idle | diag.valid_diag_window | stall_valid |
		ibuf_full | !reset_d1_l | fourth_fill_d1;

	// diag or flush must wait for the outstanding transfer
	assign icu_hold = icu_hold_req & !idle;

	// a miss in idle starts a transfer unless the FSM was told to hold
	a_miss_starts: assert property (@(posedge clk) disable iff (!reset_l)
		miss.icu_miss |-> idle ##1 (!miss.state[ic_pkg::S_IDLE_BIT] ||
		$past(diag.valid_diag_window | ibuf_full | iu_brtaken_e)));

endmodule

`default_nettype wire

/* hw/miss/ic_miss_fsm.sv */
// ******************************
// miss state machine
// one-hot sequencing of nc fetch and
// four word line fill, ack decode
// ******************************
`timescale 1ns/100ps
`default_nettype none

module ic_miss_fsm (
	input  wire                       clk,
	input  wire                       reset_l,
	input  wire [ic_pkg::ACK_W-1:0]   biu_icu_ack,
	input  wire                       iu_brtaken_e,
	input  wire                       ibuf_full,
	ic_miss_if.fsm                    miss,
	ic_diag_if.sink                   diag,
	output logic                      icu_req,
	output logic [ic_pkg::TYPE_W-1:0] icu_type,
	output logic                      bypass_ack
);

	logic [ic_pkg::STATE_W-1:0] state_q;
	logic [ic_pkg::STATE_W-1:0] state_d;
	logic any_ack;

	// error has priority over normal
	assign miss.normal_ack = biu_icu_ack[ic_pkg::ACK_NORMAL_BIT] &
		!biu_icu_ack[ic_pkg::ACK_ERROR_BIT];
	assign miss.error_ack  = biu_icu_ack[ic_pkg::ACK_ERROR_BIT];
	assign any_ack         = miss.normal_ack | miss.error_ack;
	assign bypass_ack      = any_ack;

	// ******************************
	// next state
	// ******************************
	always_comb begin
		state_d = state_q;
		case (state_q)
			ic_pkg::S_IDLE: begin
				// diag, full ibuffer or branch keep us idle
				if (diag.valid_diag_window | ibuf_full | iu_brtaken_e) begin
					state_d = ic_pkg::S_IDLE;
				end else if (miss.icu_miss) begin
					state_d = diag.cache_en ? ic_pkg::S_REQ : ic_pkg::S_NC_REQ;
				end
			end
			// either ack ends a single word fetch
			ic_pkg::S_NC_REQ: begin
				if (any_ack) begin
					state_d = ic_pkg::S_IDLE;
				end
			end
			ic_pkg::S_REQ: begin
				if (miss.error_ack) begin
					state_d = ic_pkg::S_IDLE;
				end else if (miss.normal_ack) begin
					state_d = ic_pkg::S_FILL_2ND;
				end
			end
			ic_pkg::S_FILL_2ND: begin
				if (miss.error_ack) begin
					state_d = ic_pkg::S_IDLE;
				end else if (miss.normal_ack) begin
					state_d = ic_pkg::S_REQ2;
				end
			end
			// second request of the line
			ic_pkg::S_REQ2: begin
				if (miss.error_ack) begin
					state_d = ic_pkg::S_IDLE;
				end else if (miss.normal_ack) begin
					state_d = ic_pkg::S_FILL_4TH;
				end
			end
			ic_pkg::S_FILL_4TH: begin
				if (any_ack) begin
					state_d = ic_pkg::S_IDLE;
				end
			end
			default: state_d = ic_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_l) begin
			state_q <= ic_pkg::S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign miss.state = state_q;

	// end pulses for the stall block
	assign miss.fill_end = state_q[ic_pkg::S_FILL_4TH_BIT] & any_ack;
	assign miss.nc_end   = state_q[ic_pkg::S_NC_REQ_BIT] & any_ack;

	// request held in both request states
	assign icu_req  = state_q[ic_pkg::S_NC_REQ_BIT] | state_q[ic_pkg::S_REQ_BIT];
	assign icu_type = state_q[ic_pkg::S_NC_REQ_BIT] ? ic_pkg::TYPE_NC_LD :
		ic_pkg::TYPE_CACHE_LD;

	a_state_onehot: assert property (@(posedge clk) disable iff (!reset_l)
		$onehot(state_q));

endmodule

`default_nettype wire

/* hw/miss/ic_fill_wr.sv */
// ******************************
// fill write control
// ram and tag enables, fill word address
// and delayed error and bypass flags
// ******************************
`timescale 1ns/100ps
`default_nettype none

module ic_fill_wr (
	input  wire                            clk,
	input  wire                            iu_data_e_0,
	input  wire                            misc_wrd_sel,
	ic_miss_if.wr                          miss,
	ic_diag_if.sink                        diag,
	output logic [ic_pkg::FILL_ADDR_W-1:0] fill_word_addr,
	output logic [ic_pkg::RAM_WE_W-1:0]    icu_ram_we,
	output logic                           icu_itag_we,
	output logic                           icu_tag_vld,
	output logic                           icu_tag_sel,
	output logic                           ic_data_sel,
	output logic                           ic_drty,
	output logic                           icu_bypass_q
);

	logic idle;
	logic fill_state;
	logic any_ack;

	assign idle       = miss.state[ic_pkg::S_IDLE_BIT];
	assign fill_state = miss.state[ic_pkg::S_REQ_BIT] | miss.state[ic_pkg::S_FILL_2ND_BIT] |
		miss.state[ic_pkg::S_REQ2_BIT] | miss.state[ic_pkg::S_FILL_4TH_BIT];
	assign any_ack    = miss.normal_ack | miss.error_ack;

	// word 0 in REQ, counting up to 3 in FILL_4TH
	assign fill_word_addr = {miss.state[ic_pkg::S_REQ2_BIT] | miss.state[ic_pkg::S_FILL_4TH_BIT],
		miss.state[ic_pkg::S_FILL_2ND_BIT] | miss.state[ic_pkg::S_FILL_4TH_BIT]};

	// even words to bit 1, odd words to bit 0
	assign icu_ram_we[1] = ((miss.state[ic_pkg::S_REQ_BIT] | miss.state[ic_pkg::S_REQ2_BIT]) &
		miss.normal_ack) | (diag.diag_st_cache & !misc_wrd_sel);
	assign icu_ram_we[0] = ((miss.state[ic_pkg::S_FILL_2ND_BIT] |
		miss.state[ic_pkg::S_FILL_4TH_BIT]) & miss.normal_ack) |
		(diag.diag_st_cache & misc_wrd_sel);

	// tag written on every fill ack, invalid until the last word
	assign icu_itag_we = (fill_state & any_ack) | diag.diag_st_tag | diag.flush;
	assign icu_tag_vld = ((miss.state[ic_pkg::S_FILL_4TH_BIT] & miss.normal_ack) |
		(diag.diag_st_tag & iu_data_e_0)) & !diag.flush;

	// memory address into the tag unless a diag store drives it
	assign icu_tag_sel = miss.normal_ack | (idle & !diag.valid_diag_e);
	assign ic_data_sel = any_ack;

	// flags one cycle behind the ack
	always_ff @(posedge clk) begin
		ic_drty      <= miss.error_ack;
		icu_bypass_q <= miss.state[ic_pkg::S_NC_REQ_BIT] | miss.error_ack;
	end

	// diag stores only in idle, fill writes only while busy
	a_ram_we_excl: assert property (@(posedge clk) disable iff ($isunknown(miss.state))
		!(&icu_ram_we));

endmodule

`default_nettype wire

/* hw/ic_cntl.sv */
// ******************************
// icache miss controller top
// joins diag decode, stall gen, miss FSM
// and fill write blocks
// ******************************
`timescale 1ns/100ps
`default_nettype none

module ic_cntl (
	input  wire                            clk,
	input  wire                            reset_l,
	input  wire                            iu_psr_ice,
	input  wire                            iu_flush_e,
	input  wire [ic_pkg::DIAG_W-1:0]       iu_ic_diag_e,
	input  wire                            iu_brtaken_e,
	input  wire                            ibuf_full,
	input  wire                            iu_data_e_0,
	input  wire                            icu_hit,
	input  wire [ic_pkg::ACK_W-1:0]        biu_icu_ack,
	input  wire                            misc_wrd_sel,
	output logic                           icu_req,
	output logic [ic_pkg::TYPE_W-1:0]      icu_type,
	output logic [ic_pkg::FILL_ADDR_W-1:0] fill_word_addr,
	output logic [ic_pkg::RAM_WE_W-1:0]    icu_ram_we,
	output logic                           icu_itag_we,
	output logic                           icu_tag_vld,
	output logic                           icu_tag_sel,
	output logic                           ic_data_sel,
	output logic                           bypass_ack,
	output logic                           icu_bypass_q,
	output logic                           ic_drty,
	output logic                           icu_stall,
	output logic                           icu_hold,
	output logic                           diag_ld_cache_c
);

	// raw diag or flush, combined with busy in stall gen
	logic icu_hold_req;

	ic_miss_if miss_bus ();
	ic_diag_if diag_bus ();

	// diagnostic and flush qualification
	ic_diag_decode u_diag_decode (
		.clk             (clk),
		.reset_l         (reset_l),
		.iu_psr_ice      (iu_psr_ice),
		.iu_flush_e      (iu_flush_e),
		.iu_ic_diag_e    (iu_ic_diag_e),
		.miss            (miss_bus),
		.diag            (diag_bus),
		.diag_ld_cache_c (diag_ld_cache_c),
		.icu_hold_req    (icu_hold_req)
	);

	// miss detect, branch tracking and ibuffer stall
	ic_stall_gen u_stall_gen (
		.clk          (clk),
		.reset_l      (reset_l),
		.icu_hit      (icu_hit),
		.iu_brtaken_e (iu_brtaken_e),
		.ibuf_full    (ibuf_full),
		.ic_drty      (ic_drty),
		.icu_hold_req (icu_hold_req),
		.miss         (miss_bus),
		.diag         (diag_bus),
		.icu_stall    (icu_stall),
		.icu_hold     (icu_hold)
	);

	ic_miss_fsm u_miss_fsm (
		.clk          (clk),
		.reset_l      (reset_l),
		.biu_icu_ack  (biu_icu_ack),
		.iu_brtaken_e (iu_brtaken_e),
		.ibuf_full    (ibuf_full),
		.miss         (miss_bus),
		.diag         (diag_bus),
		.icu_req      (icu_req),
		.icu_type     (icu_type),
		.bypass_ack   (bypass_ack)
	);

	// ram and tag write side
	ic_fill_wr u_fill_wr (
		.clk            (clk),
		.iu_data_e_0    (iu_data_e_0),
		.misc_wrd_sel   (misc_wrd_sel),
		.miss           (miss_bus),
		.diag           (diag_bus),
		.fill_word_addr (fill_word_addr),
		.icu_ram_we     (icu_ram_we),
		.icu_itag_we    (icu_itag_we),
		.icu_tag_vld    (icu_tag_vld),
		.icu_tag_sel    (icu_tag_sel),
		.ic_data_sel    (ic_data_sel),
		.ic_drty        (ic_drty),
		.icu_bypass_q   (icu_bypass_q)
	);

endmodule

`default_nettype wire

/* bench/ic_ref_model.svh */
// ******************************
// miss controller reference model
// cycle model stepped on each rising edge
// ******************************
`ifndef IC_REF_MODEL_SVH
`define IC_REF_MODEL_SVH

// model flops
logic [ic_pkg::STATE_W-1:0] m_state = ic_pkg::S_IDLE;
logic m_cache_en = 1'b0;
logic m_valid_diag_c = 1'b0;
logic m_diag_ld_c = 1'b0;
logic m_stall_valid = 1'b0;
logic m_fourth_d1 = 1'b0;
logic m_nc_d1 = 1'b0;
logic m_reset_d1_l = 1'b0;
logic m_drty = 1'b0;
logic m_bypass_q = 1'b0;

// predicted values for the current cycle
logic [ic_pkg::STATE_W-1:0] e_next;
logic [ic_pkg::TYPE_W-1:0] e_type;
logic [ic_pkg::FILL_ADDR_W-1:0] e_addr;
logic [ic_pkg::RAM_WE_W-1:0] e_ram_we;
logic e_nrm, e_err, e_any, e_flush, e_st_cache, e_st_tag, e_ld_cache;
logic e_valid_e, e_window, e_hold, e_miss, e_set_stall, e_stall, e_req;
logic e_itag_we, e_tag_vld, e_tag_sel, e_fill_end, e_nc_end;

// fill states: error drops back to idle, normal ack steps on
function automatic logic [ic_pkg::STATE_W-1:0] fill_next(
	input logic [ic_pkg::STATE_W-1:0] nxt);
	if (e_err) begin
		return ic_pkg::S_IDLE;
	end else if (e_nrm) begin
		return nxt;
	end
	return m_state;
endfunction

task automatic eval_model();
	logic idle;
	logic flush_req;
	logic fill;
	idle = m_state[ic_pkg::S_IDLE_BIT];
	e_err = biu_icu_ack[ic_pkg::ACK_ERROR_BIT];
	e_nrm = biu_icu_ack[ic_pkg::ACK_NORMAL_BIT] & !e_err;
	e_any = e_nrm | e_err;
	// diag and flush only act with nothing outstanding
	flush_req = iu_flush_e & iu_psr_ice;
	e_flush = flush_req & idle;
	e_st_cache = idle & iu_ic_diag_e[ic_pkg::DIAG_ST_CACHE];
	e_st_tag = idle & iu_ic_diag_e[ic_pkg::DIAG_ST_TAG];
	e_ld_cache = idle & iu_ic_diag_e[ic_pkg::DIAG_LD_CACHE];
	e_valid_e = e_flush | (|iu_ic_diag_e);
	e_window = e_valid_e | m_valid_diag_c;
	e_hold = !idle & (flush_req | (|iu_ic_diag_e));
	// no miss right after an end, an error or under a C stage diag
	e_miss = idle & (!m_cache_en | !icu_hit) & !m_valid_diag_c & !m_fourth_d1 &
		!m_nc_d1 & !m_drty;
	e_set_stall = !idle & (iu_brtaken_e | m_stall_valid);
	e_stall = e_miss | !idle | e_window | m_stall_valid | ibuf_full | !m_reset_d1_l |
		m_fourth_d1;
	e_next = m_state;
	e_req = 1'b0;
	e_type = ic_pkg::TYPE_CACHE_LD;
	e_addr = 2'd0;
	e_ram_we = 2'b00;
	e_tag_vld = 1'b0;
	fill = 1'b1;
	case (m_state)
		ic_pkg::S_IDLE: begin
			fill = 1'b0;
			if (e_miss && !e_window && !ibuf_full && !iu_brtaken_e) begin
				e_next = m_cache_en ? ic_pkg::S_REQ : ic_pkg::S_NC_REQ;
			end
		end
		ic_pkg::S_NC_REQ: begin
			fill = 1'b0;
			e_req = 1'b1;
			e_type = ic_pkg::TYPE_NC_LD;
			e_next = e_any ? ic_pkg::S_IDLE : m_state;
		end
		// even words land on enable bit 1
		ic_pkg::S_REQ: begin
			e_req = 1'b1;
			e_ram_we = {e_nrm, 1'b0};
			e_next = fill_next(ic_pkg::S_FILL_2ND);
		end
		ic_pkg::S_FILL_2ND: begin
			e_addr = 2'd1;
			e_ram_we = {1'b0, e_nrm};
			e_next = fill_next(ic_pkg::S_REQ2);
		end
		ic_pkg::S_REQ2: begin
			e_addr = 2'd2;
			e_ram_we = {e_nrm, 1'b0};
			e_next = fill_next(ic_pkg::S_FILL_4TH);
		end
		default: begin
			// last word, either ack closes the line
			e_addr = 2'd3;
			e_ram_we = {1'b0, e_nrm};
			e_tag_vld = e_nrm;
			e_next = e_any ? ic_pkg::S_IDLE : m_state;
		end
	endcase
	// word select 0 is the even word
	if (e_st_cache) begin
		e_ram_we[~misc_wrd_sel] = 1'b1;
	end
	e_itag_we = (fill & e_any) | e_st_tag | e_flush;
	e_tag_vld = (e_tag_vld | (e_st_tag & iu_data_e_0)) & !e_flush;
	e_tag_sel = e_nrm | (idle & !e_valid_e);
	e_fill_end = m_state[ic_pkg::S_FILL_4TH_BIT] & e_any;
	e_nc_end = m_state[ic_pkg::S_NC_REQ_BIT] & e_any;
endtask

// rising edge, uses the values from the last eval_model
task automatic advance_model();
	m_reset_d1_l = reset_l;
	m_drty = e_err;
	m_bypass_q = m_state[ic_pkg::S_NC_REQ_BIT] | e_err;
	if (!reset_l) begin
		m_state = ic_pkg::S_IDLE;
		m_cache_en = 1'b0;
		m_valid_diag_c = 1'b0;
		m_diag_ld_c = 1'b0;
		m_stall_valid = 1'b0;
		m_fourth_d1 = 1'b0;
		m_nc_d1 = 1'b0;
	end else begin
		// cache enable only follows the psr between transfers
		if (m_state[ic_pkg::S_IDLE_BIT]) begin
			m_cache_en = iu_psr_ice;
		end
		m_fourth_d1 = e_fill_end & !m_stall_valid;
		m_nc_d1 = e_nc_end & !m_stall_valid;
		m_stall_valid = e_set_stall;
		m_valid_diag_c = e_valid_e;
		m_diag_ld_c = e_ld_cache;
		m_state = e_next;
	end
endtask

`endif

/* bench/tb_ic_cntl.sv */
// ******************************
// miss controller testbench
// random stimulus, cycle model compare
// and directed phases with timeouts
// ******************************
`timescale 1ns/100ps
`default_nettype none

module tb_ic_cntl;

	localparam int CYCLE = 100;
	localparam int CHECK_DELAY = 75;
	localparam int PHASE_TIMEOUT = 5000;
	localparam int MIX_CYCLES = 3000;

	// event counter slots
	localparam int EV_NC_END = 0;
	localparam int EV_FILL_END = 1;
	localparam int EV_ERR = 2;
	localparam int EV_DIAG_ST = 3;
	localparam int EV_DIAG_LD = 4;
	localparam int EV_HOLD = 5;
	localparam int EV_FLUSH = 6;
	localparam int EV_FLUSH_NOP = 7;
	localparam int EV_BR_HELD = 8;
	localparam int EV_N = 9;

	logic clk;
	logic reset_l;
	logic iu_psr_ice, iu_flush_e, iu_brtaken_e, ibuf_full, iu_data_e_0;
	logic icu_hit, misc_wrd_sel;
	logic [ic_pkg::DIAG_W-1:0] iu_ic_diag_e;
	logic [ic_pkg::ACK_W-1:0] biu_icu_ack;
	logic icu_req, icu_itag_we, icu_tag_vld, icu_tag_sel, ic_data_sel, bypass_ack;
	logic icu_bypass_q, ic_drty, icu_stall, icu_hold, diag_ld_cache_c;
	logic [ic_pkg::TYPE_W-1:0] icu_type;
	logic [ic_pkg::FILL_ADDR_W-1:0] fill_word_addr;
	logic [ic_pkg::RAM_WE_W-1:0] icu_ram_we;

	integer seed = 32'h3bdb_56e4;
	string test_name = "reset";
	logic stim_en = 1'b0;
	int seen [EV_N];
	// stimulus rates, out of 64
	int ice_rate, hit_rate, ack_rate, err_rate, diag_rate, flush_rate, br_rate, full_rate;

	`include "ic_ref_model.svh"

	ic_cntl dut0 (
		.clk             (clk),
		.reset_l         (reset_l),
		.iu_psr_ice      (iu_psr_ice),
		.iu_flush_e      (iu_flush_e),
		.iu_ic_diag_e    (iu_ic_diag_e),
		.iu_brtaken_e    (iu_brtaken_e),
		.ibuf_full       (ibuf_full),
		.iu_data_e_0     (iu_data_e_0),
		.icu_hit         (icu_hit),
		.biu_icu_ack     (biu_icu_ack),
		.misc_wrd_sel    (misc_wrd_sel),
		.icu_req         (icu_req),
		.icu_type        (icu_type),
		.fill_word_addr  (fill_word_addr),
		.icu_ram_we      (icu_ram_we),
		.icu_itag_we     (icu_itag_we),
		.icu_tag_vld     (icu_tag_vld),
		.icu_tag_sel     (icu_tag_sel),
		.ic_data_sel     (ic_data_sel),
		.bypass_ack      (bypass_ack),
		.icu_bypass_q    (icu_bypass_q),
		.ic_drty         (ic_drty),
		.icu_stall       (icu_stall),
		.icu_hold        (icu_hold),
		.diag_ld_cache_c (diag_ld_cache_c)
	);

	initial begin
		clk = 1'b0;
		forever #(CYCLE / 2) clk = ~clk;
	end

	// ******************************
	// compare tasks
	// ******************************
	task automatic report_mismatch(input string sig, input string exp, input string act);
		$display("CHECK FAILED test %s signal %s expected %s actual %s at %0t",
			test_name, sig, exp, act, $time);
		$display("Finished with errors");
		$fatal(1, "mismatch on %s", sig);
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic act);
		if (act !== exp) begin
			report_mismatch(sig, $sformatf("%b", exp), $sformatf("%b", act));
		end
	endtask

	task automatic check_type(input string sig, input logic [ic_pkg::TYPE_W-1:0] exp,
		input logic [ic_pkg::TYPE_W-1:0] act);
		if (act !== exp) begin
			report_mismatch(sig, $sformatf("%h", exp), $sformatf("%h", act));
		end
	endtask

	task automatic check_ram_we(input string sig, input logic [ic_pkg::RAM_WE_W-1:0] exp,
		input logic [ic_pkg::RAM_WE_W-1:0] act);
		if (act !== exp) begin
			report_mismatch(sig, $sformatf("%b", exp), $sformatf("%b", act));
		end
	endtask

	task automatic check_fill_addr(input string sig,
		input logic [ic_pkg::FILL_ADDR_W-1:0] exp, input logic [ic_pkg::FILL_ADDR_W-1:0] act);
		if (act !== exp) begin
			report_mismatch(sig, $sformatf("%h", exp), $sformatf("%h", act));
		end
	endtask

	task automatic compare_outputs();
		check_bit("icu_req", e_req, icu_req);
		check_type("icu_type", e_type, icu_type);
		check_fill_addr("fill_word_addr", e_addr, fill_word_addr);
		check_ram_we("icu_ram_we", e_ram_we, icu_ram_we);
		check_bit("icu_itag_we", e_itag_we, icu_itag_we);
		check_bit("icu_tag_vld", e_tag_vld, icu_tag_vld);
		check_bit("icu_tag_sel", e_tag_sel, icu_tag_sel);
		check_bit("ic_data_sel", e_any, ic_data_sel);
		check_bit("bypass_ack", e_any, bypass_ack);
		check_bit("icu_bypass_q", m_bypass_q, icu_bypass_q);
		check_bit("ic_drty", m_drty, ic_drty);
		check_bit("icu_stall", e_stall, icu_stall);
		check_bit("icu_hold", e_hold, icu_hold);
		check_bit("diag_ld_cache_c", m_diag_ld_c, diag_ld_cache_c);
	endtask

	// pre-edge view of the cycle, so an event counts once
	task automatic count_events();
		if (e_nc_end) seen[EV_NC_END]++;
		if (e_fill_end & e_nrm) seen[EV_FILL_END]++;
		if (e_err & !m_state[ic_pkg::S_IDLE_BIT]) seen[EV_ERR]++;
		if (e_st_cache | e_st_tag) seen[EV_DIAG_ST]++;
		if (m_diag_ld_c) seen[EV_DIAG_LD]++;
		if (e_hold) seen[EV_HOLD]++;
		if (e_flush) seen[EV_FLUSH]++;
		if (iu_flush_e & !iu_psr_ice & m_state[ic_pkg::S_IDLE_BIT]) seen[EV_FLUSH_NOP]++;
		// branch still pending once the fill is back in idle
		if (m_stall_valid & m_state[ic_pkg::S_IDLE_BIT]) seen[EV_BR_HELD]++;
	endtask

	// step on the rising edge, check late in the cycle after the new inputs
	initial begin
		forever begin
			@(posedge clk);
			eval_model();
			if (reset_l) begin
				count_events();
			end
			advance_model();
			#(CHECK_DELAY);
			if (reset_l) begin
				eval_model();
				compare_outputs();
			end
		end
	end

	// ******************************
	// stimulus
	// ******************************
	function automatic logic roll(input int rate);
		int r;
		r = $random(seed);
		return ((r & 63) < rate);
	endfunction

	task automatic drive_inputs();
		int pick;
		iu_psr_ice = roll(ice_rate);
		icu_hit = roll(hit_rate);
		iu_flush_e = roll(flush_rate);
		iu_brtaken_e = roll(br_rate);
		ibuf_full = roll(full_rate);
		iu_data_e_0 = roll(32);
		misc_wrd_sel = roll(32);
		pick = $random(seed);
		// at most one diag strobe per cycle
		iu_ic_diag_e = '0;
		if (roll(diag_rate)) begin
			iu_ic_diag_e = 4'b0001 << (pick & 3);
		end
		// the bus only answers an outstanding transfer
		biu_icu_ack = '0;
		if (!m_state[ic_pkg::S_IDLE_BIT]) begin
			if (roll(err_rate)) begin
				biu_icu_ack = ((pick & 4) != 0) ? 2'b11 : 2'b10;
			end else if (roll(ack_rate)) begin
				biu_icu_ack = 2'b01;
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (stim_en) begin
				drive_inputs();
			end
		end
	end

	// quarter past the rising edge, clear of stimulus and checks
	task automatic next_slot();
		@(posedge clk);
		#(CYCLE / 4);
	endtask

	task automatic set_mode(input string name, input int ice, input int hit, input int ack,
		input int err, input int diag, input int flush, input int br, input int full);
		test_name = name;
		ice_rate = ice;
		hit_rate = hit;
		ack_rate = ack;
		err_rate = err;
		diag_rate = diag;
		flush_rate = flush;
		br_rate = br;
		full_rate = full;
		stim_en = 1'b1;
	endtask

	task automatic wait_seen(input int kind, input int need);
		int base;
		int cycles;
		base = seen[kind];
		cycles = 0;
		while (seen[kind] - base < need) begin
			if (cycles >= PHASE_TIMEOUT) begin
				$display("timeout in %s, event %0d seen %0d of %0d times",
					test_name, kind, seen[kind] - base, need);
				$display("Finished with errors");
				$fatal(1, "wait timed out");
			end
			next_slot();
			cycles++;
		end
	endtask

	initial begin
		reset_l = 1'b0;
		iu_psr_ice = 1'b0;
		iu_flush_e = 1'b0;
		iu_ic_diag_e = '0;
		iu_brtaken_e = 1'b0;
		ibuf_full = 1'b0;
		iu_data_e_0 = 1'b0;
		icu_hit = 1'b0;
		biu_icu_ack = '0;
		misc_wrd_sel = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_l = 1'b1;
		next_slot();
		// cache off, every miss is a single word fetch
		set_mode("nc_fetch", 0, 32, 16, 0, 0, 0, 0, 4);
		wait_seen(EV_NC_END, 4);
		set_mode("cache_fill", 64, 16, 24, 0, 0, 0, 0, 4);
		wait_seen(EV_FILL_END, 4);
		set_mode("error_ack", 64, 16, 12, 6, 0, 0, 0, 2);
		wait_seen(EV_ERR, 3);
		set_mode("diag", 48, 32, 16, 1, 24, 0, 2, 2);
		wait_seen(EV_DIAG_ST, 4);
		wait_seen(EV_DIAG_LD, 2);
		wait_seen(EV_HOLD, 2);
		set_mode("flush", 32, 32, 16, 1, 2, 16, 2, 2);
		wait_seen(EV_FLUSH, 2);
		wait_seen(EV_FLUSH_NOP, 2);
		set_mode("branch", 64, 8, 8, 1, 0, 0, 16, 2);
		wait_seen(EV_BR_HELD, 3);
		set_mode("mixed", 40, 32, 16, 2, 6, 4, 6, 6);
		repeat (MIX_CYCLES) next_slot();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
common/ic_pkg.sv
common/ic_miss_if.sv
common/ic_diag_if.sv
hw/ic_diag_decode.sv
hw/ic_stall_gen.sv
hw/miss/ic_miss_fsm.sv
hw/miss/ic_fill_wr.sv
hw/ic_cntl.sv
bench/tb_ic_cntl.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_ic_cntl
RTL_TOP    = ic_cntl
FILELIST   = build.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# a failing run ends in $fatal, which gives a nonzero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
